/* filelist.f */
+incdir+design
design/cpuPkg.sv
design/hazardIf.sv
design/pipeStage.sv
design/controlUnit.sv
design/registerFile.sv
design/alu.sv
design/hazardUnit.sv
design/datapath.sv
design/cpuCore.sv
verification/cpuCore_checker.sv
verification/cpuCore_tb.sv

/* verification/cpuCore_tb.sv */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuCore_tb import cpuPkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int CYCLE_LIMIT = 200;
    localparam int NUM_PROGS = 5;
    localparam int MAX_OUTS = 8;
    localparam int POST_HALT_CYCLES = 6;
    localparam logic [31:0] RAND_SEED = 32'h1c07_7bd4;
    localparam word_t HALT_WORD = {`ALU_OP, 6'd0, `FUNC_HLT};

    logic Clk;
    logic reset;
    word_t instrAddr;
    logic instrRead;
    word_t instrData;
    word_t dataAddr;
    logic dataRead;
    logic dataWrite;
    word_t dataWriteData;
    word_t dataReadData;
    logic halted;
    word_t numInst;
    word_t outputPort;
    logic outputValid;

    word_t instrMem [256];
    word_t dataMem [256];
    // Reference copy of the initial data contents
    word_t refMem [256];

    string progName [NUM_PROGS];
    word_t progCode [NUM_PROGS][16];
    word_t expOut [NUM_PROGS][MAX_OUTS];
    int expOutCount [NUM_PROGS];
    word_t expRetired [NUM_PROGS];

    int checkCount;
    int errorCount;

    cpuCore i_dut (
        .Clk(Clk),
        .reset(reset),
        .instrAddr(instrAddr),
        .instrRead(instrRead),
        .instrData(instrData),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData),
        .halted(halted),
        .numInst(numInst),
        .outputPort(outputPort),
        .outputValid(outputValid)
    );

    // Single-cycle memories answer only while their read strobe is high
    assign instrData = instrRead ? instrMem[instrAddr[7:0]] : 'x;
    assign dataReadData = dataRead ? dataMem[dataAddr[7:0]] : 'x;

    always @(posedge Clk) begin
        if (dataWrite) begin
            dataMem[dataAddr[7:0]] <= dataWriteData;
        end
    end

    initial begin
        Clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) Clk = ~Clk;
        end
    end

    initial begin
        #(NUM_PROGS * CYCLE_LIMIT * CLK_PERIOD);
        $display("Timeout: run exceeded %0d cycles per program", CYCLE_LIMIT);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Something failed");
        $finish;
    end

    function automatic word_t aluInstr(input logic [1:0] rs, input logic [1:0] rt,
                                       input logic [1:0] rd, input logic [5:0] func);
        return {`ALU_OP, rs, rt, rd, func};
    endfunction

    function automatic word_t immInstr(input logic [3:0] op, input logic [1:0] rs,
                                       input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jumpInstr(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic buildPrograms();
        for (int p = 0; p < NUM_PROGS; p++) begin
            for (int i = 0; i < 16; i++) begin
                progCode[p][i] = HALT_WORD;
            end
            for (int i = 0; i < MAX_OUTS; i++) begin
                expOut[p][i] = '0;
            end
        end

        // Dependent ALU chain where every result is forwarded
        progName[0] = "alu_chain";
        progCode[0][0] = immInstr(`ADI_OP, 0, 1, 8'h35);
        progCode[0][1] = immInstr(`ADI_OP, 1, 2, 8'hFA);
        progCode[0][2] = aluInstr(1, 2, 3, `FUNC_ADD);
        progCode[0][3] = aluInstr(3, 0, 0, `FUNC_WWD);
        progCode[0][4] = aluInstr(2, 3, 0, `FUNC_SUB);
        progCode[0][5] = aluInstr(0, 3, 1, `FUNC_AND);
        progCode[0][6] = aluInstr(1, 2, 2, `FUNC_ORR);
        progCode[0][7] = aluInstr(2, 0, 3, `FUNC_NOT);
        progCode[0][8] = immInstr(`ORI_OP, 1, 0, 8'h85);
        progCode[0][9] = aluInstr(3, 0, 0, `FUNC_WWD);
        progCode[0][10] = aluInstr(0, 0, 0, `FUNC_WWD);
        progCode[0][11] = immInstr(`LHI_OP, 0, 1, 8'hA7);
        progCode[0][12] = aluInstr(1, 0, 2, `FUNC_ADD);
        progCode[0][13] = aluInstr(2, 0, 0, `FUNC_WWD);
        // 0x35+0x2F, ~(0x40|0x2F), 0x40|0x85 zero-extended, 0xA700+0xC5
        expOut[0][0] = 16'h0064;
        expOut[0][1] = 16'hFF90;
        expOut[0][2] = 16'h00C5;
        expOut[0][3] = 16'hA7C5;
        expOutCount[0] = 4;
        expRetired[0] = 16'd15;

        progName[1] = "load_store";
        progCode[1][0] = immInstr(`ADI_OP, 0, 1, 8'h12);
        progCode[1][1] = immInstr(`LHI_OP, 0, 2, 8'h5A);
        progCode[1][2] = immInstr(`ORI_OP, 2, 2, 8'h3C);
        progCode[1][3] = immInstr(`SWD_OP, 1, 2, 8'h04);
        progCode[1][4] = immInstr(`LWD_OP, 1, 3, 8'h04);
        progCode[1][5] = aluInstr(1, 3, 0, `FUNC_ADD);
        progCode[1][6] = aluInstr(0, 0, 0, `FUNC_WWD);
        progCode[1][7] = immInstr(`LWD_OP, 1, 3, 8'h20);
        progCode[1][8] = aluInstr(3, 0, 0, `FUNC_WWD);
        progCode[1][9] = immInstr(`LWD_OP, 1, 2, 8'hFE);
        progCode[1][10] = aluInstr(2, 0, 0, `FUNC_WWD);
        expOut[1][0] = 16'h5A4E;
        expOut[1][1] = refMem[8'h32];
        expOut[1][2] = refMem[8'h10];
        expOutCount[1] = 3;
        expRetired[1] = 16'd12;

        progName[2] = "branches";
        progCode[2][0] = immInstr(`ADI_OP, 0, 1, 8'h07);
        progCode[2][1] = immInstr(`ADI_OP, 0, 2, 8'h07);
        progCode[2][2] = immInstr(`BNE_OP, 1, 2, 8'h03);
        progCode[2][3] = aluInstr(1, 0, 0, `FUNC_WWD);
        progCode[2][4] = immInstr(`BEQ_OP, 1, 2, 8'h02);
        progCode[2][5] = immInstr(`ADI_OP, 1, 1, 8'h01);
        progCode[2][6] = aluInstr(1, 0, 0, `FUNC_WWD);
        progCode[2][7] = immInstr(`ADI_OP, 0, 3, 8'h11);
        progCode[2][8] = immInstr(`BNE_OP, 3, 1, 8'h02);
        progCode[2][9] = aluInstr(0, 0, 0, `FUNC_WWD);
        progCode[2][11] = immInstr(`BEQ_OP, 3, 1, 8'h01);
        progCode[2][12] = aluInstr(3, 0, 0, `FUNC_WWD);
        progCode[2][13] = aluInstr(1, 0, 0, `FUNC_WWD);
        expOut[2][0] = 16'h0007;
        expOut[2][1] = 16'h0011;
        expOut[2][2] = 16'h0007;
        expOutCount[2] = 3;
        expRetired[2] = 16'd11;

        // JAL at 4 links 5 and JPR comes back there
        progName[3] = "jumps";
        progCode[3][0] = immInstr(`ADI_OP, 0, 1, 8'h03);
        progCode[3][1] = jumpInstr(`JMP_OP, 12'd4);
        progCode[3][2] = aluInstr(1, 0, 0, `FUNC_WWD);
        progCode[3][4] = jumpInstr(`JAL_OP, 12'd8);
        progCode[3][5] = aluInstr(1, 0, 0, `FUNC_WWD);
        progCode[3][8] = aluInstr(2, 0, 0, `FUNC_WWD);
        progCode[3][9] = aluInstr(2, 0, 0, `FUNC_JPR);
        progCode[3][10] = aluInstr(1, 0, 0, `FUNC_WWD);
        expOut[3][0] = 16'h0005;
        expOut[3][1] = 16'h0003;
        expOutCount[3] = 2;
        expRetired[3] = 16'd7;

        // Countdown loop of three passes
        progName[4] = "loop_halt";
        progCode[4][0] = immInstr(`ADI_OP, 0, 1, 8'h03);
        progCode[4][1] = immInstr(`ADI_OP, 1, 1, 8'hFF);
        progCode[4][2] = aluInstr(1, 0, 0, `FUNC_WWD);
        progCode[4][3] = immInstr(`BNE_OP, 1, 0, 8'hFD);
        progCode[4][5] = aluInstr(1, 0, 0, `FUNC_WWD);
        expOut[4][0] = 16'h0002;
        expOut[4][1] = 16'h0001;
        expOut[4][2] = 16'h0000;
        expOutCount[4] = 3;
        expRetired[4] = 16'd11;
    endtask

    task automatic loadProgram(input int p);
        for (int a = 0; a < 256; a++) begin
            if (a < 16) begin
                instrMem[a] = progCode[p][a];
            end else begin
                instrMem[a] = HALT_WORD;
            end
            dataMem[a] <= refMem[a];
        end
    endtask

    task automatic runProgram(input int p);
        word_t got [$];
        word_t retiredAtHalt;
        int cycles;

        @(posedge Clk);
        #1;
        reset = 1'b1;
        loadProgram(p);
        repeat (10) @(posedge Clk);
        #1;
        reset = 1'b0;

        cycles = 0;
        while (!halted && cycles < CYCLE_LIMIT / 2) begin
            @(negedge Clk);
            if (outputValid) begin
                got.push_back(outputPort);
            end
            cycles++;
        end

        checkCount++;
        if (!halted) begin
            errorCount++;
            $display("%s: core did not halt within %0d cycles", progName[p], CYCLE_LIMIT / 2);
        end
        checkCount++;
        if (got.size() != expOutCount[p]) begin
            errorCount++;
            $display("%s: core wrote %0d output words but %0d were expected",
                     progName[p], got.size(), expOutCount[p]);
        end
        for (int i = 0; i < got.size() && i < expOutCount[p]; i++) begin
            checkCount++;
            if (got[i] !== expOut[p][i]) begin
                errorCount++;
                $display("MISMATCH %s output %0d: expected %h, actual %h",
                         progName[p], i, expOut[p][i], got[i]);
            end
        end
        checkCount++;
        if (numInst !== expRetired[p]) begin
            errorCount++;
            $display("MISMATCH %s retired count: expected %0d, actual %0d",
                     progName[p], expRetired[p], numInst);
        end

        // Nothing may move once halted
        if (halted) begin
            retiredAtHalt = numInst;
            repeat (POST_HALT_CYCLES) begin
                @(negedge Clk);
                checkCount++;
                if (!halted || outputValid || numInst !== retiredAtHalt) begin
                    errorCount++;
                    $display("%s: core left the halted state (halted %b, outputValid %b)",
                             progName[p], halted, outputValid);
                end
            end
        end
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
        reset = 1'b1;
        void'($urandom(RAND_SEED));
        for (int a = 0; a < 256; a++) begin
            refMem[a] = word_t'($urandom());
            instrMem[a] = HALT_WORD;
            dataMem[a] <= refMem[a];
        end
        buildPrograms();

        for (int p = 0; p < NUM_PROGS; p++) begin
            runProgram(p);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verification/cpuCore_checker.sv */
`timescale 1ns/100ps

module cpuCore_checker (
    input logic Clk,
    input logic reset,
    input logic instrRead,
    input logic dataRead,
    input logic dataWrite,
    input logic halted,
    input logic outputValid
);

    // Data memory sees one access per cycle
    noReadWithWrite: assert property (@(posedge Clk) disable iff (reset)
        !(dataRead && dataWrite))
        else $error("dataRead and dataWrite are high in the same cycle");

    haltHolds: assert property (@(posedge Clk) disable iff (reset)
        halted |=> halted)
        else $error("halted fell while reset was low");

    noFetchWhenHalted: assert property (@(posedge Clk) disable iff (reset)
        halted |-> !instrRead)
        else $error("instruction fetch while halted");

    // First cycle out of reset is quiet
    quietAfterReset: assert property (@(posedge Clk)
        $fell(reset) |-> !instrRead && !dataRead && !dataWrite && !outputValid)
        else $error("strobe active in the first cycle after reset");

endmodule

bind cpuCore cpuCore_checker protocolChecks (
    .Clk(Clk),
    .reset(reset),
    .instrRead(instrRead),
    .dataRead(dataRead),
    .dataWrite(dataWrite),
    .halted(halted),
    .outputValid(outputValid)
);

/* design/cpuCore.sv */
`timescale 1ns/100ps

module cpuCore import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    output word_t instrAddr,
    output logic instrRead,
    input word_t instrData,
    output word_t dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output word_t dataWriteData,
    input word_t dataReadData,
    output logic halted,
    output word_t numInst,
    output word_t outputPort,
    output logic outputValid
);

    word_t decodeInstr;
    ctrl_t ctrl;

    controlUnit control (
        .instr(decodeInstr),
        .ctrl(ctrl)
    );

    datapath core (
        .Clk(Clk),
        .reset(reset),
        .instrAddr(instrAddr),
        .instrRead(instrRead),
        .instrData(instrData),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData),
        .decodeInstr(decodeInstr),
        .ctrl(ctrl),
        .halted(halted),
        .numInst(numInst),
        .outputPort(outputPort),
        .outputValid(outputValid)
    );

endmodule

/* design/datapath.sv */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module datapath import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    output word_t instrAddr,
    output logic instrRead,
    input word_t instrData,
    output word_t dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output word_t dataWriteData,
    input word_t dataReadData,
    output word_t decodeInstr,
    input ctrl_t ctrl,
    output logic halted,
    output word_t numInst,
    output word_t outputPort,
    output logic outputValid
);

    word_t pc;
    word_t nextPc;
    logic running;
    logic haltSeen;
    logic fetchEn;

    ifIdPayload_t ifIdIn, ifIdOut;
    idExPayload_t idExIn, idExOut;
    exMemPayload_t exMemIn, exMemOut;
    memWbPayload_t memWbIn, memWbOut;
    logic ifIdValid, idExValid, exMemValid, memWbValid;

    regIdx_t idRs, idRt, idRd, idDst;
    word_t rsVal, rtVal;
    word_t jumpTarget;
    logic jumpTaken;
    logic haltDecode;

    word_t fwdA, fwdB, operandB;
    word_t aluResult, linkAddr, branchTarget, memAddr, exResult;
    logic branchTaken;
    logic exRedirect;
    word_t wbValue;

    hazardIf hz();

    // Fetch
    assign fetchEn = running && !haltSeen;
    assign instrRead = fetchEn;
    assign instrAddr = pc;
    assign ifIdIn = '{pc: pc, instr: instrData};

    always_comb begin
        if (exRedirect) begin
            nextPc = idExOut.ctrl.isJumpR ? fwdA : branchTarget;
        end else if (jumpTaken) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pc + `WORD_SIZE'd1;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
            running <= 1'b0;
            haltSeen <= 1'b0;
        end else begin
            running <= 1'b1;
            if (haltDecode) begin
                haltSeen <= 1'b1;
            end
            if (fetchEn && (exRedirect || (!hz.stall && !haltDecode))) begin
                pc <= nextPc;
            end
        end
    end

    pipeStage #(.payload_t(ifIdPayload_t)) ifIdStage (
        .Clk(Clk), .reset(reset),
        .hold(hz.stall), .flush(exRedirect || jumpTaken || haltDecode),
        .inValid(fetchEn), .inData(ifIdIn),
        .outValid(ifIdValid), .outData(ifIdOut)
    );

    // Decode
    assign decodeInstr = ifIdOut.instr;
    assign idRs = ifIdOut.instr[11:10];
    assign idRt = ifIdOut.instr[9:8];
    assign idRd = ifIdOut.instr[7:6];
    // JAL links into register 2
    assign idDst = (ctrl.isJumpI && ctrl.regWrite) ? 2'd2 : (ctrl.regDst ? idRd : idRt);
    assign jumpTarget = {ifIdOut.pc[15:12], ifIdOut.instr[11:0]};
    assign jumpTaken = ifIdValid && ctrl.isJumpI;
    assign haltDecode = ifIdValid && ctrl.halt && !exRedirect;

    registerFile regFile (
        .Clk(Clk), .reset(reset),
        .readIdxA(idRs), .readIdxB(idRt),
        .writeIdx(memWbOut.dst), .writeEnable(memWbValid && memWbOut.ctrl.regWrite),
        .writeData(wbValue),
        .readDataA(rsVal), .readDataB(rtVal)
    );

    assign idExIn = '{
        pc: ifIdOut.pc,
        ctrl: ctrl,
        rsVal: rsVal,
        rtVal: rtVal,
        rs: idRs,
        rt: idRt,
        dst: idDst,
        opcode: ifIdOut.instr[15:12],
        func: ifIdOut.instr[5:0],
        imm: {{8{ifIdOut.instr[7]}}, ifIdOut.instr[7:0]}
    };

    pipeStage #(.payload_t(idExPayload_t)) idExStage (
        .Clk(Clk), .reset(reset),
        .hold(1'b0), .flush(hz.stall || exRedirect),
        .inValid(ifIdValid), .inData(idExIn),
        .outValid(idExValid), .outData(idExOut)
    );

    assign hz.idRs = idRs;
    assign hz.idRt = idRt;
    assign hz.idUseRs = ifIdValid && ctrl.useRs;
    assign hz.idUseRt = ifIdValid && ctrl.useRt;
    assign hz.exRs = idExOut.rs;
    assign hz.exRt = idExOut.rt;
    assign hz.exDst = idExOut.dst;
    assign hz.exMemRead = idExValid && idExOut.ctrl.memRead;
    assign hz.memDst = exMemOut.dst;
    assign hz.memRegWrite = exMemValid && exMemOut.ctrl.regWrite;
    assign hz.wbDst = memWbOut.dst;
    assign hz.wbRegWrite = memWbValid && memWbOut.ctrl.regWrite;

    hazardUnit hazards (
        .hz(hz.hazardSide)
    );

    // Execute
    always_comb begin
        case (hz.forwardA)
            2'b01: fwdA = exMemOut.result;
            2'b10: fwdA = wbValue;
            default: fwdA = idExOut.rsVal;
        endcase
        case (hz.forwardB)
            2'b01: fwdB = exMemOut.result;
            2'b10: fwdB = wbValue;
            default: fwdB = idExOut.rtVal;
        endcase
    end

    // ORI takes a zero-extended immediate
    always_comb begin
        if (!idExOut.ctrl.aluSrc) begin
            operandB = fwdB;
        end else if (idExOut.opcode == `ORI_OP) begin
            operandB = {8'h00, idExOut.imm[7:0]};
        end else begin
            operandB = idExOut.imm;
        end
    end

    alu execAlu (
        .opcode(idExOut.opcode), .func(idExOut.func),
        .operandA(fwdA), .operandB(operandB),
        .result(aluResult), .branchTaken(branchTaken)
    );

    assign linkAddr = idExOut.pc + `WORD_SIZE'd1;
    assign branchTarget = linkAddr + idExOut.imm;
    assign memAddr = fwdA + idExOut.imm;
    assign exResult = idExOut.ctrl.isAlu ? aluResult
                    : (idExOut.ctrl.isJumpI ? linkAddr : memAddr);
    assign exRedirect = idExValid
                     && ((idExOut.ctrl.isBranch && branchTaken) || idExOut.ctrl.isJumpR);

    assign exMemIn = '{
        ctrl: idExOut.ctrl,
        result: exResult,
        storeData: fwdB,
        dst: idExOut.dst
    };

    pipeStage #(.payload_t(exMemPayload_t)) exMemStage (
        .Clk(Clk), .reset(reset),
        .hold(1'b0), .flush(1'b0),
        .inValid(idExValid), .inData(exMemIn),
        .outValid(exMemValid), .outData(exMemOut)
    );

    // Memory
    assign dataAddr = exMemOut.result;
    assign dataRead = exMemValid && exMemOut.ctrl.memRead;
    assign dataWrite = exMemValid && exMemOut.ctrl.memWrite;
    assign dataWriteData = exMemOut.storeData;

    assign memWbIn = '{
        ctrl: exMemOut.ctrl,
        result: exMemOut.result,
        loadData: dataReadData,
        dst: exMemOut.dst
    };

    pipeStage #(.payload_t(memWbPayload_t)) memWbStage (
        .Clk(Clk), .reset(reset),
        .hold(1'b0), .flush(1'b0),
        .inValid(exMemValid), .inData(memWbIn),
        .outValid(memWbValid), .outData(memWbOut)
    );

    // Writeback and retirement
    assign wbValue = memWbOut.ctrl.memToReg ? memWbOut.loadData : memWbOut.result;

    always_ff @(posedge Clk) begin
        if (reset) begin
            halted <= 1'b0;
            numInst <= '0;
            outputPort <= '0;
            outputValid <= 1'b0;
        end else begin
            outputValid <= memWbValid && memWbOut.ctrl.wwd;
            if (memWbValid) begin
                numInst <= numInst + `WORD_SIZE'd1;
                if (memWbOut.ctrl.wwd) begin
                    outputPort <= memWbOut.result;
                end
                if (memWbOut.ctrl.halt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit (
    hazardIf.hazardSide hz
);

    // Memory stage is younger, so it wins
    always_comb begin
        if (hz.memRegWrite && hz.memDst == hz.exRs) begin
            hz.forwardA = 2'b01;
        end else if (hz.wbRegWrite && hz.wbDst == hz.exRs) begin
            hz.forwardA = 2'b10;
        end else begin
            hz.forwardA = 2'b00;
        end
    end

    always_comb begin
        if (hz.memRegWrite && hz.memDst == hz.exRt) begin
            hz.forwardB = 2'b01;
        end else if (hz.wbRegWrite && hz.wbDst == hz.exRt) begin
            hz.forwardB = 2'b10;
        end else begin
            hz.forwardB = 2'b00;
        end
    end

    // Load in execute feeding the instruction in decode
    assign hz.stall = hz.exMemRead
                   && ((hz.idUseRs && hz.exDst == hz.idRs)
                    || (hz.idUseRt && hz.exDst == hz.idRt));

endmodule

/* design/alu.sv */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module alu import cpuPkg::*; (
    input logic [3:0] opcode,
    input logic [5:0] func,
    input word_t operandA,
    input word_t operandB,
    output word_t result,
    output logic branchTaken
);

    aluOp_t aluOp;

    always_comb begin
        case (opcode)
            `ALU_OP: begin
                case (func)
                    `FUNC_ADD: aluOp = ALU_ADD;
                    `FUNC_SUB: aluOp = ALU_SUB;
                    `FUNC_AND: aluOp = ALU_AND;
                    `FUNC_ORR: aluOp = ALU_OR;
                    `FUNC_NOT: aluOp = ALU_NOT;
                    default: aluOp = ALU_PASSA;
                endcase
            end
            `ADI_OP: aluOp = ALU_ADD;
            `ORI_OP: aluOp = ALU_OR;
            `LHI_OP: aluOp = ALU_LHI;
            default: aluOp = ALU_PASSA;
        endcase
    end

    always_comb begin
        case (aluOp)
            ALU_ADD: result = operandA + operandB;
            ALU_SUB: result = operandA - operandB;
            ALU_AND: result = operandA & operandB;
            ALU_OR: result = operandA | operandB;
            ALU_NOT: result = ~operandA;
            ALU_LHI: result = {operandB[7:0], 8'h00};
            default: result = operandA;
        endcase
    end

    assign branchTaken = (opcode == `BEQ_OP && operandA == operandB)
                      || (opcode == `BNE_OP && operandA != operandB);

endmodule

/* design/registerFile.sv */
`timescale 1ns/100ps

module registerFile import cpuPkg::*; (
    input logic Clk,
    input logic reset,
    input regIdx_t readIdxA,
    input regIdx_t readIdxB,
    input regIdx_t writeIdx,
    input logic writeEnable,
    input word_t writeData,
    output word_t readDataA,
    output word_t readDataB
);

    word_t regs [4];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIdx] <= writeData;
        end
    end

    // Writeback lands in decode in the same cycle
    assign readDataA = (writeEnable && writeIdx == readIdxA) ? writeData : regs[readIdxA];
    assign readDataB = (writeEnable && writeIdx == readIdxB) ? writeData : regs[readIdxB];

endmodule

/* design/controlUnit.sv */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module controlUnit import cpuPkg::*; (
    input word_t instr,
    output ctrl_t ctrl
);

    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = instr[15:12];
    assign func = instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            `ALU_OP: begin
                case (func)
                    `FUNC_ADD, `FUNC_SUB, `FUNC_AND, `FUNC_ORR: begin
                        ctrl.regDst = 1'b1;
                        ctrl.isAlu = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.useRs = 1'b1;
                        ctrl.useRt = 1'b1;
                    end
                    `FUNC_NOT: begin
                        ctrl.regDst = 1'b1;
                        ctrl.isAlu = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.useRs = 1'b1;
                    end
                    `FUNC_JPR: begin
                        ctrl.isJumpR = 1'b1;
                        ctrl.useRs = 1'b1;
                    end
                    // rs passes through the ALU to the output port
                    `FUNC_WWD: begin
                        ctrl.isAlu = 1'b1;
                        ctrl.wwd = 1'b1;
                        ctrl.useRs = 1'b1;
                    end
                    `FUNC_HLT: ctrl.halt = 1'b1;
                    default: ctrl = '0;
                endcase
            end
            `ADI_OP, `ORI_OP: begin
                ctrl.aluSrc = 1'b1;
                ctrl.isAlu = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.useRs = 1'b1;
            end
            `LHI_OP: begin
                ctrl.aluSrc = 1'b1;
                ctrl.isAlu = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `LWD_OP: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.useRs = 1'b1;
            end
            `SWD_OP: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.useRs = 1'b1;
                ctrl.useRt = 1'b1;
            end
            `BNE_OP, `BEQ_OP: begin
                ctrl.isBranch = 1'b1;
                ctrl.useRs = 1'b1;
                ctrl.useRt = 1'b1;
            end
            `JMP_OP: ctrl.isJumpI = 1'b1;
            `JAL_OP: begin
                ctrl.isJumpI = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* design/pipeStage.sv */
`timescale 1ns/100ps

module pipeStage #(
    parameter type payload_t = logic
) (
    input logic Clk,
    input logic reset,
    input logic hold,
    input logic flush,
    input logic inValid,
    input payload_t inData,
    output logic outValid,
    output payload_t outData
);

    always_ff @(posedge Clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    // Payload only matters while valid
    always_ff @(posedge Clk) begin
        if (!hold) begin
            outData <= inData;
        end
    end

endmodule

/* design/hazardIf.sv */
`timescale 1ns/100ps

interface hazardIf import cpuPkg::*; ();
    regIdx_t idRs;
    regIdx_t idRt;
    logic idUseRs;
    logic idUseRt;
    regIdx_t exRs;
    regIdx_t exRt;
    regIdx_t exDst;
    logic exMemRead;
    regIdx_t memDst;
    logic memRegWrite;
    regIdx_t wbDst;
    logic wbRegWrite;
    // 00 register file, 01 memory stage, 10 writeback stage
    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic stall;

    modport datapathSide (
        output idRs, idRt, idUseRs, idUseRt, exRs, exRt, exDst, exMemRead,
        output memDst, memRegWrite, wbDst, wbRegWrite,
        input forwardA, forwardB, stall
    );

    modport hazardSide (
        input idRs, idRt, idUseRs, idUseRt, exRs, exRt, exDst, exMemRead,
        input memDst, memRegWrite, wbDst, wbRegWrite,
        output forwardA, forwardB, stall
    );
endinterface

/* design/cpuPkg.sv */
`include "cpu_consts.svh"

package cpuPkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [1:0] regIdx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_PASSA,
        ALU_LHI
    } aluOp_t;

    typedef struct packed {
        logic regDst;
        logic aluSrc;
        logic isAlu;
        logic isBranch;
        logic isJumpR;
        logic isJumpI;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic wwd;
        logic halt;
        logic useRs;
        logic useRt;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifIdPayload_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t rsVal;
        word_t rtVal;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t dst;
        logic [3:0] opcode;
        logic [5:0] func;
        word_t imm;
    } idExPayload_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
        word_t storeData;
        regIdx_t dst;
    } exMemPayload_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
        word_t loadData;
        regIdx_t dst;
    } memWbPayload_t;

endpackage

/* design/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_SIZE 16

// Opcodes in instr[15:12]
`define BNE_OP 4'd0
`define BEQ_OP 4'd1
`define ADI_OP 4'd4
`define ORI_OP 4'd5
`define LHI_OP 4'd6
`define LWD_OP 4'd7
`define SWD_OP 4'd8
`define JMP_OP 4'd9
`define JAL_OP 4'd10
`define ALU_OP 4'd15

// Function codes in instr[5:0], used with ALU_OP
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_JPR 6'd25
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`endif
